//--- logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int WORD_W         = 32;   // Register width
    localparam int BYTE_W         = 8;    // FIFO bridge byte
    localparam int ADDR_W         = 4;    // Register address from high nibble of command
    localparam int BYTES_PER_WORD = 4;
    localparam logic [1:0] LAST_BYTE = 2'(BYTES_PER_WORD - 1);  // Final byte index

    // Command opcodes in the low nibble of the command byte
    localparam logic [ADDR_W-1:0] OP_READ  = 4'hA;
    localparam logic [ADDR_W-1:0] OP_WRITE = 4'h5;

    // Register map
    localparam logic [ADDR_W-1:0] ADR_COMP_CONFIG       = 4'd1;
    localparam logic [ADDR_W-1:0] ADR_PULSE_CTRL        = 4'd2;
    localparam logic [ADDR_W-1:0] ADR_HALFSTRIPS        = 4'd5;   // RO mirror
    localparam logic [ADDR_W-1:0] ADR_HALFSTRIPS_EXPECT = 4'd6;
    localparam logic [ADDR_W-1:0] ADR_HALFSTRIPS_ERRCNT = 4'd7;   // RO
    localparam logic [ADDR_W-1:0] ADR_ADC               = 4'd8;
    localparam logic [ADDR_W-1:0] ADR_DDD               = 4'd9;
    localparam logic [ADDR_W-1:0] ADR_COMPOUT_ERRCNT    = 4'd10;  // RO
    localparam logic [ADDR_W-1:0] ADR_THRESHOLDS_ERRCNT = 4'd11;  // RO
    localparam logic [ADDR_W-1:0] ADR_ACTIVE_STRIP_MASK = 4'd12;

    localparam logic [WORD_W-1:0] UNMAPPED_WORD = 32'hDEADBEEF;

    // Comparator configuration fields
    localparam int CC_PKTIME_LO = 0;
    localparam int CC_PKTIME_HI = 2;
    localparam int CC_PKMODE_LO = 3;
    localparam int CC_PKMODE_HI = 4;
    localparam int CC_LCTRST    = 5;
    localparam int CC_CDAC_EN_N = 6;
    localparam int CC_CDAC_DIN  = 7;
    localparam int CC_CDAC_SCLK = 8;

    // Pulse control fields
    localparam int PC_FIRE         = 0;
    localparam int PC_WIDTH_LO     = 1;
    localparam int PC_WIDTH_HI     = 4;
    localparam int PC_PDAC_EN_N    = 5;
    localparam int PC_PDAC_DIN     = 6;
    localparam int PC_PDAC_SCLK    = 7;
    localparam int PC_HS_ERR_RST   = 8;
    localparam int PC_CO_ERR_RST   = 9;
    localparam int PC_INJECT       = 10;
    localparam int PC_BX_DELAY_LO  = 11;
    localparam int PC_BX_DELAY_HI  = 13;
    localparam int PC_CO_EXPECT    = 14;
    localparam int PC_TRIAD_LO     = 15;
    localparam int PC_TRIAD_HI     = 18;
    localparam int PC_TRIAD1       = 19;
    localparam int PC_CO_LAST      = 20;  // Read-only status
    localparam int PC_PULSER_READY = 21;  // Read-only status
    localparam int PC_TH_ERR_RST   = 23;

    // Bit-banged serial port fields shared by ADC and delay chip
    localparam int BB_SEL_N = 0;
    localparam int BB_MOSI  = 1;
    localparam int BB_SCLK  = 2;
    localparam int BB_MISO  = 3;  // Read-only data-in pin

    // Writable bits and reset values
    localparam logic [WORD_W-1:0] COMP_CONFIG_MASK = 32'h000001FF;
    localparam logic [WORD_W-1:0] PULSE_CTRL_MASK  = 32'h008FFFFF;
    localparam logic [WORD_W-1:0] BITBANG_MASK     = 32'h00000007;
    localparam logic [WORD_W-1:0] PULSE_CTRL_RESET = 32'h00000020;  // Pulse DAC disabled
    localparam logic [WORD_W-1:0] BITBANG_RESET    = 32'h00000001;  // Select released

    // Host link FSM
    typedef enum logic [1:0] {
        IDLE,       // Waiting for command byte
        RD_BYTE,    // Presenting read word to host
        WR_BYTE,    // Collecting write data
        WR_COMMIT   // One-cycle register strobe
    } link_state_t;

endpackage

`default_nettype wire

//--- logic/host_link.sv
`timescale 1ns/1ps
`default_nettype none

module host_link
    import ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // USB FIFO bridge side
    input  logic              ft_rxf_n,     // Active-low byte available
    input  logic              ft_rd_n,      // Host consumes read byte
    input  logic [BYTE_W-1:0] ft_data_in,
    output logic [BYTE_W-1:0] ft_data_out,
    output logic              rd_active,
    output logic              wr_active,

    // Register bank side
    output logic              reg_we,       // Single-cycle write strobe
    output logic [ADDR_W-1:0] reg_addr,
    output logic [WORD_W-1:0] reg_wdata,
    input  logic [WORD_W-1:0] reg_rdata
);

    link_state_t       state;
    logic [1:0]        byte_idx;    // Byte position within word
    logic [ADDR_W-1:0] addr_q;      // Latched command address
    logic [WORD_W-1:0] rd_word;     // Read snapshot

    logic              rx_valid;
    logic [ADDR_W-1:0] cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    logic              cmd_take;    // Command byte accepted this edge

    assign rx_valid = ~ft_rxf_n;
    assign cmd_op   = ft_data_in[ADDR_W-1:0];          // Low nibble
    assign cmd_addr = ft_data_in[BYTE_W-1:ADDR_W];     // High nibble
    assign cmd_take = (state == IDLE) && rx_valid;

    // ------------------------------------------------------------------------
    // Command FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= IDLE;
            byte_idx <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    byte_idx <= '0;
                    if (rx_valid)
                    begin
                        if (cmd_op == OP_READ)
                            state <= RD_BYTE;
                        else if (cmd_op == OP_WRITE)
                            state <= WR_BYTE;
                        // Anything else is dropped
                    end
                end

                RD_BYTE:
                begin
                    if (!ft_rd_n)                   // Host took current byte
                    begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == LAST_BYTE)
                            state <= IDLE;
                    end
                end

                WR_BYTE:
                begin
                    if (rx_valid)
                    begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == LAST_BYTE)
                            state <= WR_COMMIT;
                    end
                end

                WR_COMMIT: state <= IDLE;           // Strobe lasts this cycle only

                default:   state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Address, write assembly and read snapshot
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            addr_q    <= '0;
            rd_word   <= '0;
            reg_wdata <= '0;
        end
        else
        begin
            if (cmd_take)
            begin
                addr_q <= cmd_addr;
                if (cmd_op == OP_READ)
                    rd_word <= reg_rdata;           // Whole word frozen at once
            end

            // LSB first
            if ((state == WR_BYTE) && rx_valid)
                reg_wdata[byte_idx*BYTE_W +: BYTE_W] <= ft_data_in;
        end
    end

    // Before acceptance the bank must already see the new address
    assign reg_addr = (state == IDLE) ? cmd_addr : addr_q;

    assign reg_we    = (state == WR_COMMIT);
    assign rd_active = (state == RD_BYTE);
    assign wr_active = (state == WR_BYTE) || (state == WR_COMMIT);

    // Zero outside a read
    assign ft_data_out = rd_active ? rd_word[byte_idx*BYTE_W +: BYTE_W] : '0;

endmodule

`default_nettype wire

//--- logic/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs
    import ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Host link port
    input  logic              reg_we,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic [WORD_W-1:0] reg_wdata,
    output logic [WORD_W-1:0] reg_rdata,

    // Status from board
    input  logic [WORD_W-1:0] halfstrips,
    input  logic [WORD_W-1:0] halfstrips_errcnt,
    input  logic [WORD_W-1:0] compout_errcnt,
    input  logic [WORD_W-1:0] thresholds_errcnt,
    input  logic              compout_last,
    input  logic              pulser_ready,
    input  logic              adc_miso,
    input  logic              ddd_miso,

    // Comparator configuration
    output logic [2:0]        pktime,
    output logic [1:0]        pkmode,
    output logic              lctrst,
    output logic              cdac_en_n,
    output logic              cdac_din,
    output logic              cdac_sclk,

    // Pulse control
    output logic              fire_pulse,
    output logic [3:0]        pulse_width,
    output logic              pdac_en_n,
    output logic              pdac_din,
    output logic              pdac_sclk,
    output logic              halfstrips_errcnt_rst,
    output logic              compout_errcnt_rst,
    output logic              thresholds_errcnt_rst,
    output logic              compin_inject,
    output logic [2:0]        bx_delay,
    output logic              compout_expect,
    output logic [3:0]        triad_persist,
    output logic              triad_persist1,

    // Strips
    output logic [WORD_W-1:0] halfstrips_expect,
    output logic [WORD_W-1:0] active_strip_mask,

    // Bit-banged serial ports
    output logic              adc_cs_n,
    output logic              adc_mosi,
    output logic              adc_sclk,
    output logic              ddd_al_n,
    output logic              ddd_mosi,
    output logic              ddd_sclk
);

    logic [WORD_W-1:0] comp_config_q;
    logic [WORD_W-1:0] pulse_ctrl_q;
    logic [WORD_W-1:0] hs_expect_q;
    logic [WORD_W-1:0] strip_mask_q;
    logic [WORD_W-1:0] adc_q;
    logic [WORD_W-1:0] ddd_q;

    logic [WORD_W-1:0] pulse_ctrl_rd;   // Stored bits plus live status
    logic [WORD_W-1:0] adc_rd;
    logic [WORD_W-1:0] ddd_rd;

    // ------------------------------------------------------------------------
    // Register storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            comp_config_q <= '0;
            pulse_ctrl_q  <= PULSE_CTRL_RESET;
            hs_expect_q   <= '0;
            strip_mask_q  <= '0;
            adc_q         <= BITBANG_RESET;
            ddd_q         <= BITBANG_RESET;
        end
        else if (reg_we)
        begin
            // Masked bits are never kept
            case (reg_addr)
                ADR_COMP_CONFIG:       comp_config_q <= reg_wdata & COMP_CONFIG_MASK;
                ADR_PULSE_CTRL:        pulse_ctrl_q  <= reg_wdata & PULSE_CTRL_MASK;
                ADR_HALFSTRIPS_EXPECT: hs_expect_q   <= reg_wdata;
                ADR_ACTIVE_STRIP_MASK: strip_mask_q  <= reg_wdata;
                ADR_ADC:               adc_q         <= reg_wdata & BITBANG_MASK;
                ADR_DDD:               ddd_q         <= reg_wdata & BITBANG_MASK;
                default: ;                          // RO mirrors and holes
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Field outputs
    // ------------------------------------------------------------------------
    assign pktime    = comp_config_q[CC_PKTIME_HI:CC_PKTIME_LO];
    assign pkmode    = comp_config_q[CC_PKMODE_HI:CC_PKMODE_LO];
    assign lctrst    = comp_config_q[CC_LCTRST];
    assign cdac_en_n = comp_config_q[CC_CDAC_EN_N];
    assign cdac_din  = comp_config_q[CC_CDAC_DIN];
    assign cdac_sclk = comp_config_q[CC_CDAC_SCLK];

    assign fire_pulse            = pulse_ctrl_q[PC_FIRE];
    assign pulse_width           = pulse_ctrl_q[PC_WIDTH_HI:PC_WIDTH_LO];
    assign pdac_en_n             = pulse_ctrl_q[PC_PDAC_EN_N];
    assign pdac_din              = pulse_ctrl_q[PC_PDAC_DIN];
    assign pdac_sclk             = pulse_ctrl_q[PC_PDAC_SCLK];
    assign halfstrips_errcnt_rst = pulse_ctrl_q[PC_HS_ERR_RST];
    assign compout_errcnt_rst    = pulse_ctrl_q[PC_CO_ERR_RST];
    assign thresholds_errcnt_rst = pulse_ctrl_q[PC_TH_ERR_RST];   // Bit 23
    assign compin_inject         = pulse_ctrl_q[PC_INJECT];
    assign bx_delay              = pulse_ctrl_q[PC_BX_DELAY_HI:PC_BX_DELAY_LO];
    assign compout_expect        = pulse_ctrl_q[PC_CO_EXPECT];
    assign triad_persist         = pulse_ctrl_q[PC_TRIAD_HI:PC_TRIAD_LO];
    assign triad_persist1        = pulse_ctrl_q[PC_TRIAD1];

    assign halfstrips_expect = hs_expect_q;
    assign active_strip_mask = strip_mask_q;

    assign adc_cs_n = adc_q[BB_SEL_N];
    assign adc_mosi = adc_q[BB_MOSI];
    assign adc_sclk = adc_q[BB_SCLK];
    assign ddd_al_n = ddd_q[BB_SEL_N];     // Active-low address latch
    assign ddd_mosi = ddd_q[BB_MOSI];
    assign ddd_sclk = ddd_q[BB_SCLK];

    // ------------------------------------------------------------------------
    // Readback
    // ------------------------------------------------------------------------
    always_comb
    begin
        pulse_ctrl_rd                  = pulse_ctrl_q;
        pulse_ctrl_rd[PC_CO_LAST]      = compout_last;
        pulse_ctrl_rd[PC_PULSER_READY] = pulser_ready;

        adc_rd          = adc_q;
        adc_rd[BB_MISO] = adc_miso;
        ddd_rd          = ddd_q;
        ddd_rd[BB_MISO] = ddd_miso;
    end

    always_comb
    begin
        case (reg_addr)
            ADR_COMP_CONFIG:       reg_rdata = comp_config_q;
            ADR_PULSE_CTRL:        reg_rdata = pulse_ctrl_rd;
            ADR_HALFSTRIPS:        reg_rdata = halfstrips;        // Live
            ADR_HALFSTRIPS_EXPECT: reg_rdata = hs_expect_q;
            ADR_HALFSTRIPS_ERRCNT: reg_rdata = halfstrips_errcnt;
            ADR_ADC:               reg_rdata = adc_rd;
            ADR_DDD:               reg_rdata = ddd_rd;
            ADR_COMPOUT_ERRCNT:    reg_rdata = compout_errcnt;
            ADR_THRESHOLDS_ERRCNT: reg_rdata = thresholds_errcnt;
            ADR_ACTIVE_STRIP_MASK: reg_rdata = strip_mask_q;
            default:               reg_rdata = UNMAPPED_WORD;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/board_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctrl
    import ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // USB FIFO bridge
    input  logic              ft_rxf_n,
    input  logic              ft_rd_n,
    input  logic [BYTE_W-1:0] ft_data_in,
    output logic [BYTE_W-1:0] ft_data_out,
    output logic              rd_active,
    output logic              wr_active,

    // Board status
    input  logic [WORD_W-1:0] halfstrips,
    input  logic [WORD_W-1:0] halfstrips_errcnt,
    input  logic [WORD_W-1:0] compout_errcnt,
    input  logic [WORD_W-1:0] thresholds_errcnt,
    input  logic              compout_last,
    input  logic              pulser_ready,
    input  logic              adc_miso,
    input  logic              ddd_miso,

    // Comparator and pulser pins
    output logic [2:0]        pktime,
    output logic [1:0]        pkmode,
    output logic              lctrst,
    output logic              cdac_en_n,
    output logic              cdac_din,
    output logic              cdac_sclk,
    output logic              fire_pulse,
    output logic [3:0]        pulse_width,
    output logic              pdac_en_n,
    output logic              pdac_din,
    output logic              pdac_sclk,
    output logic              halfstrips_errcnt_rst,
    output logic              compout_errcnt_rst,
    output logic              thresholds_errcnt_rst,
    output logic              compin_inject,
    output logic [2:0]        bx_delay,
    output logic              compout_expect,
    output logic [3:0]        triad_persist,
    output logic              triad_persist1,
    output logic [WORD_W-1:0] halfstrips_expect,
    output logic [WORD_W-1:0] active_strip_mask,

    // ADC and delay chip serial lines
    output logic              adc_cs_n,
    output logic              adc_mosi,
    output logic              adc_sclk,
    output logic              ddd_al_n,
    output logic              ddd_mosi,
    output logic              ddd_sclk
);

    // Link to bank
    logic              reg_we;
    logic [ADDR_W-1:0] reg_addr;
    logic [WORD_W-1:0] reg_wdata;
    logic [WORD_W-1:0] reg_rdata;

    host_link u_host_link (.*);    // Byte protocol

    ctrl_regs u_ctrl_regs (.*);    // Register bank and pins

endmodule

`default_nettype wire

//--- tb/board_ctrl_chk.sv
`timescale 1ns/1ps
`default_nettype none

module board_ctrl_chk
    import ctrl_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        reg_we,
    input logic        rd_active,
    input logic        wr_active,
    input logic        ft_rxf_n,
    input link_state_t state,
    input logic [1:0]  byte_idx
);

    int violations = 0;     // Number of failed assertions

    // Write strobe lasts one cycle
    we_single: assert property (@(posedge clk) disable iff (!rst_n) reg_we |=> !reg_we)
        else
        begin
            violations = violations + 1;
            $error("reg_we high for two consecutive cycles");
        end

    // Read and write never overlap
    rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
                                 !(rd_active && wr_active))
        else
        begin
            violations = violations + 1;
            $error("rd_active and wr_active high together");
        end

    // Strobe only right after the last write byte
    we_after_data: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we |-> ($past(state) == WR_BYTE && $past(byte_idx) == LAST_BYTE
                    && !$past(ft_rxf_n)))
        else
        begin
            violations = violations + 1;
            $error("reg_we without a completed write");
        end

endmodule

`default_nettype wire

//--- tb/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ----------------------------------------------------------------------------
// Bridge model
// ----------------------------------------------------------------------------
// All tasks start and end 1 ns after a rising edge
task automatic idle_gap();
    int n;
    n = int'(next_random() % 32'(gap_max + 1));
    repeat (n)
    begin
        @(posedge clk);
        #1;
    end
endtask

task automatic send_byte(input logic [7:0] b);
    idle_gap();
    ft_data_in = b;
    ft_rxf_n   = 1'b0;              // Byte available
    @(posedge clk);
    #1;
    ft_rxf_n   = 1'b1;
endtask

task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    send_byte({addr, OP_WRITE});
    check_value("wr_active", 32'(wr_active), 32'd1);
    for (int i = 0; i < 4; i++)
        send_byte(data[i*8 +: 8]);  // LSB first
    while (wr_active)
    begin
        @(posedge clk);
        #1;
    end
    if (write_mask(addr) != '0)
        shadow[addr] = data & write_mask(addr);
endtask

task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
    send_byte({addr, OP_READ});
    for (int i = 0; i < 4; i++)
    begin
        check_value("rd_active", 32'(rd_active), 32'd1);
        idle_gap();
        data[i*8 +: 8] = ft_data_out;
        ft_rd_n = 1'b0;             // Consume byte
        @(posedge clk);
        #1;
        ft_rd_n = 1'b1;
    end
    check_value("rd_active", 32'(rd_active), 32'd0);
endtask

task automatic set_status_random();
    halfstrips        = next_random();
    halfstrips_errcnt = next_random();
    compout_errcnt    = next_random();
    thresholds_errcnt = next_random();
    {compout_last, pulser_ready, adc_miso, ddd_miso} = 4'(next_random());
endtask

// ----------------------------------------------------------------------------
// Expected values
// ----------------------------------------------------------------------------
function automatic logic [31:0] write_mask(input logic [3:0] addr);
    case (addr)
        ADR_COMP_CONFIG:       return 32'h0000_01FF;
        ADR_PULSE_CTRL:        return 32'h008F_FFFF;
        ADR_ADC, ADR_DDD:      return 32'h0000_0007;
        ADR_HALFSTRIPS_EXPECT: return 32'hFFFF_FFFF;
        ADR_ACTIVE_STRIP_MASK: return 32'hFFFF_FFFF;
        default:               return 32'h0;     // Mirrors and holes
    endcase
endfunction

task automatic reset_model();
    foreach (shadow[i])
        shadow[i] = '0;
    shadow[ADR_PULSE_CTRL] = 32'h0000_0020;  // Pulse DAC enable off
    shadow[ADR_ADC]        = 32'h0000_0001;  // Selects released
    shadow[ADR_DDD]        = 32'h0000_0001;
endtask

function automatic logic [31:0] expected_read(input logic [3:0] addr);
    logic [31:0] w;
    w = shadow[addr];
    case (addr)
        ADR_PULSE_CTRL:
        begin
            w[PC_CO_LAST]      = compout_last;
            w[PC_PULSER_READY] = pulser_ready;
        end
        ADR_ADC:               w[BB_MISO] = adc_miso;
        ADR_DDD:               w[BB_MISO] = ddd_miso;
        ADR_HALFSTRIPS:        w = halfstrips;
        ADR_HALFSTRIPS_ERRCNT: w = halfstrips_errcnt;
        ADR_COMPOUT_ERRCNT:    w = compout_errcnt;
        ADR_THRESHOLDS_ERRCNT: w = thresholds_errcnt;
        default:
            if (write_mask(addr) == '0)
                w = 32'hDEAD_BEEF;
    endcase
    return w;
endfunction

task automatic check_register(input logic [3:0] addr);
    logic [31:0] got;
    reg_read(addr, got);
    check_value($sformatf("reg_rdata[0x%h]", addr), got, expected_read(addr));
endtask

task automatic check_all_registers();
    for (int a = 0; a < 16; a++)
        check_register(4'(a));
endtask

task automatic check_pins();
    logic [31:0] cc;
    logic [31:0] pc;
    cc = shadow[ADR_COMP_CONFIG];
    pc = shadow[ADR_PULSE_CTRL];
    check_value("pktime..cdac_sclk",
                32'({cdac_sclk, cdac_din, cdac_en_n, lctrst, pkmode, pktime}),
                32'(cc[CC_CDAC_SCLK:CC_PKTIME_LO]));
    check_value("fire_pulse..triad_persist1",
                32'({triad_persist1, triad_persist, compout_expect, bx_delay,
                     compin_inject, compout_errcnt_rst, halfstrips_errcnt_rst,
                     pdac_sclk, pdac_din, pdac_en_n, pulse_width, fire_pulse}),
                32'(pc[PC_TRIAD1:PC_FIRE]));
    check_value("thresholds_errcnt_rst", 32'(thresholds_errcnt_rst),
                32'(pc[PC_TH_ERR_RST]));
    check_value("halfstrips_expect", halfstrips_expect, shadow[ADR_HALFSTRIPS_EXPECT]);
    check_value("active_strip_mask", active_strip_mask, shadow[ADR_ACTIVE_STRIP_MASK]);
    check_value("adc_cs_n/mosi/sclk", 32'({adc_sclk, adc_mosi, adc_cs_n}),
                32'(shadow[ADR_ADC][BB_SCLK:BB_SEL_N]));
    check_value("ddd_al_n/mosi/sclk", 32'({ddd_sclk, ddd_mosi, ddd_al_n}),
                32'(shadow[ADR_DDD][BB_SCLK:BB_SEL_N]));
endtask

// ----------------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------------
task automatic test_reset_state();
    check_value("rd_active", 32'(rd_active), 32'd0);
    check_value("wr_active", 32'(wr_active), 32'd0);
    check_value("ft_data_out", 32'(ft_data_out), 32'd0);
    check_pins();                   // Reset levels
    check_all_registers();
endtask

task automatic test_write_readback();
    for (int round = 0; round < 2; round++)
        for (int a = 0; a < 16; a++)
            if (write_mask(4'(a)) != '0)
            begin
                reg_write(4'(a), next_random());
                check_register(4'(a));
                check_pins();
            end
endtask

task automatic test_readonly_mirrors();
    for (int round = 0; round < 4; round++)
    begin
        set_status_random();
        {compout_last, pulser_ready} = 2'(round);   // All four combinations
        check_register(ADR_HALFSTRIPS);
        check_register(ADR_HALFSTRIPS_ERRCNT);
        check_register(ADR_COMPOUT_ERRCNT);
        check_register(ADR_THRESHOLDS_ERRCNT);
        check_register(ADR_PULSE_CTRL);
    end
    // Mirrors and holes ignore writes
    for (int a = 0; a < 16; a++)
        if (write_mask(4'(a)) == '0)
            reg_write(4'(a), next_random());
    check_all_registers();
    check_pins();
endtask

task automatic test_bitbang_ports();
    for (int round = 0; round < 4; round++)
    begin
        {adc_miso, ddd_miso} = 2'(round);
        reg_write(ADR_ADC, next_random());
        reg_write(ADR_DDD, next_random());
        check_register(ADR_ADC);
        check_register(ADR_DDD);
        check_pins();
    end
endtask

task automatic test_invalid_traffic();
    logic [3:0] op;
    for (int a = 0; a < 16; a++)
        if (a == 0 || a == 3 || a == 4 || a >= 13)
            check_register(4'(a));
    for (int k = 0; k < 16; k++)
    begin
        op = 4'(k);
        if (op != OP_READ && op != OP_WRITE)
        begin
            send_byte({4'(next_random()), op});
            check_value("rd_active", 32'(rd_active), 32'd0);
            check_value("wr_active", 32'(wr_active), 32'd0);
        end
    end
    check_all_registers();
    check_pins();
endtask

task automatic test_back_pressure();
    gap_max = 3;                    // Up to 3 idle cycles per byte
    test_write_readback();
    check_all_registers();
    gap_max = 0;
endtask

`endif

//--- tb/tb_board_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_ctrl
    import ctrl_pkg::*;
();

    // Roughly 2000 cycles of traffic with gaps so the limit leaves wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk = 1'b0;
    logic              rst_n;

    // USB FIFO bridge
    logic              ft_rxf_n;
    logic              ft_rd_n;
    logic [BYTE_W-1:0] ft_data_in;
    logic [BYTE_W-1:0] ft_data_out;
    logic              rd_active;
    logic              wr_active;

    // Board status inputs
    logic [WORD_W-1:0] halfstrips;
    logic [WORD_W-1:0] halfstrips_errcnt;
    logic [WORD_W-1:0] compout_errcnt;
    logic [WORD_W-1:0] thresholds_errcnt;
    logic              compout_last;
    logic              pulser_ready;
    logic              adc_miso;
    logic              ddd_miso;

    // Board control pins
    logic [2:0]        pktime;
    logic [1:0]        pkmode;
    logic              lctrst, cdac_en_n, cdac_din, cdac_sclk;
    logic              fire_pulse;
    logic [3:0]        pulse_width;
    logic              pdac_en_n, pdac_din, pdac_sclk;
    logic              halfstrips_errcnt_rst, compout_errcnt_rst, thresholds_errcnt_rst;
    logic              compin_inject;
    logic [2:0]        bx_delay;
    logic              compout_expect;
    logic [3:0]        triad_persist;
    logic              triad_persist1;
    logic [WORD_W-1:0] halfstrips_expect;
    logic [WORD_W-1:0] active_strip_mask;
    logic              adc_cs_n, adc_mosi, adc_sclk;
    logic              ddd_al_n, ddd_mosi, ddd_sclk;

    logic [WORD_W-1:0] shadow [16];     // Expected register contents
    logic [31:0]       rng_state;
    int                gap_max;         // Largest idle gap in cycles where 0 means full speed
    int                cycle_count = 0;

    board_ctrl UUT (.*);

    bind host_link board_ctrl_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_we    (reg_we),
        .rd_active (rd_active),
        .wr_active (wr_active),
        .ft_rxf_n  (ft_rxf_n),
        .state     (state),
        .byte_idx  (byte_idx)
    );

    always #5 clk = ~clk;                // 100 MHz

    // ------------------------------------------------------------------------
    // Watchdog and reporting
    // ------------------------------------------------------------------------
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the host link stopped answering", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    // Xorshift32
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    `include "tb_tasks.svh"

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial
    begin
        rng_state  = 32'd53;
        gap_max    = 0;
        rst_n      = 1'b0;
        ft_rxf_n   = 1'b1;              // Bridge empty
        ft_rd_n    = 1'b1;
        ft_data_in = '0;
        set_status_random();
        reset_model();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_write_readback();
        test_readonly_mirrors();
        test_bitbang_ports();
        test_invalid_traffic();
        test_back_pressure();

        if (UUT.u_host_link.u_chk.violations == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            $display("Protocol assertions on the host link failed");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+tb
logic/ctrl_pkg.sv
logic/host_link.sv
logic/ctrl_regs.sv
logic/board_ctrl.sv
tb/board_ctrl_chk.sv
tb/tb_board_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_board_ctrl
FILELIST  = src.f
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: sim clean

# Build, run, then decide on the log contents
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
